// File: hw/addrCtrlPkg.sv
`default_nettype none

package addrCtrlPkg;

	// ==============================
	// sizes
	// ==============================
	localparam int NUM_MASTERS = 2;			// master ports
	localparam int MASTER_W = 1;			// bits to encode a master number
	localparam int NUM_SLAVES = 3;			// slave ports, decode-error slave included
	localparam int SLAVE_W = 2;				// bits to encode a slave number
	localparam int DERR_SLAVE = 2;			// decode-error slave sits at the top index
	localparam int ID_W = 2;				// master ID width
	localparam int ADDR_W = 20;
	localparam int OPEN_TRANS_MAX = 3;		// outstanding transactions per master

	// ==============================
	// memory map
	// ==============================
	localparam int UPPER_BIT = 15;			// upper compare bit
	localparam int LOWER_BIT = 12;			// lower compare bit, bits below are don't care
	localparam int BASE_W = ADDR_W - UPPER_BIT;		// width of the base field, bits 19:15
	localparam int SLOT_W = UPPER_BIT - LOWER_BIT;	// width of the slot field, bits 14:12

	// one entry per memory slave, none for the decode-error slave
	localparam logic [NUM_SLAVES-2:0][BASE_W-1:0] SLOT_BASE = {5'd1, 5'd0};
	localparam logic [NUM_SLAVES-2:0][SLOT_W-1:0] SLOT_MIN = {3'd0, 3'd0};
	localparam logic [NUM_SLAVES-2:0][SLOT_W-1:0] SLOT_MAX = {3'd7, 3'd3};

	// bit per master and slave, master 1 cannot reach slave 0
	localparam logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0] CONNECTIVITY = {3'b110, 3'b111};

	// ==============================
	// types
	// ==============================
	typedef logic [ADDR_W-1:0] addrT;
	typedef logic [ID_W-1:0] idT;
	typedef logic [7:0] lenT;				// burst length
	typedef logic [MASTER_W-1:0] masterT;
	typedef logic [SLAVE_W-1:0] slaveT;
	typedef logic [MASTER_W+ID_W-1:0] srcIdT;	// master number then master ID
	typedef logic [1:0] openCntT;

	typedef enum logic {
		MUX_IDLE,		// waiting for a grant
		MUX_SEND		// request presented to the slave
	} muxStateT;

endpackage

`default_nettype wire

// File: hw/masterQualify.sv
`default_nettype none

module masterQualify
(
	input wire logic sysClk,
	input wire logic arstN,
	input wire addrCtrlPkg::addrT masterAddr,		// address to decode
	input wire logic masterValid,					// master has a request pending
	input wire addrCtrlPkg::masterT masterId,		// number of this master port
	input wire logic openTransInc,					// request accepted this cycle
	input wire logic openTransDec,					// data side retired one transaction
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] stopTrans,
	output addrCtrlPkg::slaveT targetSlave,
	output logic validQual
);

	logic [addrCtrlPkg::BASE_W-1:0] baseField;
	logic [addrCtrlPkg::SLOT_W-1:0] slotField;
	addrCtrlPkg::openCntT openCnt;			// outstanding transactions
	addrCtrlPkg::slaveT openSlave;			// slave the open transactions go to
	logic countOk;
	logic dependOk;

	// ==============================
	// address decode
	// ==============================
	assign baseField = masterAddr[addrCtrlPkg::ADDR_W-1:addrCtrlPkg::UPPER_BIT];
	assign slotField = masterAddr[addrCtrlPkg::UPPER_BIT-1:addrCtrlPkg::LOWER_BIT];

	always_comb
	begin
		targetSlave = addrCtrlPkg::slaveT'(addrCtrlPkg::DERR_SLAVE);	// unmapped or unconnected
		// walk downwards so the lowest matching slave wins
		for (int s = addrCtrlPkg::NUM_SLAVES - 2; s >= 0; s--)
		begin
			if ((baseField == addrCtrlPkg::SLOT_BASE[s]) &&
				(slotField >= addrCtrlPkg::SLOT_MIN[s]) &&
				(slotField <= addrCtrlPkg::SLOT_MAX[s]) &&
				addrCtrlPkg::CONNECTIVITY[masterId][s])
			begin
				targetSlave = addrCtrlPkg::slaveT'(s);
			end
		end
	end

	// ==============================
	// open transaction tracking
	// ==============================
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			openCnt <= '0;
			openSlave <= '0;
		end
		else
		begin
			if (openTransInc && !openTransDec)
				openCnt <= openCnt + 1'b1;
			else if (openTransDec && !openTransInc)
				openCnt <= openCnt - 1'b1;
			// inc and dec together cancel

			if (openTransInc)
				openSlave <= targetSlave;	// dependence check keeps this equal while open
		end
	end

	// ==============================
	// qualification
	// ==============================
	assign countOk = (openCnt < addrCtrlPkg::OPEN_TRANS_MAX);
	// single thread, no switching slaves with transactions in flight
	assign dependOk = (openCnt == '0) || (targetSlave == openSlave);

	assign validQual = masterValid && countOk && dependOk
		&& !stopTrans[targetSlave];				// slave side asked to hold off

endmodule

`default_nettype wire

// File: hw/roundRobinArb.sv
`default_nettype none

module roundRobinArb
(
	input wire logic sysClk,
	input wire logic arstN,
	input wire logic [addrCtrlPkg::NUM_MASTERS-1:0] requestor,	// qualified requests
	input wire logic arbEnable,									// grant taken, move on
	output logic [addrCtrlPkg::NUM_MASTERS-1:0] grant,			// one-hot or zero
	output addrCtrlPkg::masterT grantEnc,
	output logic grantValid
);

	addrCtrlPkg::masterT priPtr;			// first master looked at

	// first requestor at or after the pointer, wrapping round
	always_comb
	begin
		int idx;
		grant = '0;
		grantEnc = '0;
		for (int i = addrCtrlPkg::NUM_MASTERS - 1; i >= 0; i--)
		begin
			idx = int'(priPtr) + i;
			if (idx >= addrCtrlPkg::NUM_MASTERS)
				idx = idx - addrCtrlPkg::NUM_MASTERS;
			if (requestor[idx])
			begin
				grant = '0;
				grant[idx] = 1'b1;
				grantEnc = addrCtrlPkg::masterT'(idx);	// nearest to the pointer wins
			end
		end
	end

	assign grantValid = |requestor;

	// pointer goes just past the master served
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			priPtr <= '0;						// master 0 first out of reset
		else if (arbEnable)
		begin
			if (int'(grantEnc) == addrCtrlPkg::NUM_MASTERS - 1)
				priPtr <= '0;
			else
				priPtr <= grantEnc + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/targetMux.sv
`default_nettype none

module targetMux
(
	input wire logic sysClk,
	input wire logic arstN,

	// ==============================
	// arbiter and qualify side
	// ==============================
	input wire logic [addrCtrlPkg::NUM_MASTERS-1:0] grant,
	input wire addrCtrlPkg::masterT grantEnc,
	input wire logic grantValid,
	input wire addrCtrlPkg::slaveT [addrCtrlPkg::NUM_MASTERS-1:0] targetSlave,
	output logic arbEnable,

	// master address channels
	input wire addrCtrlPkg::idT [addrCtrlPkg::NUM_MASTERS-1:0] masterAid,
	input wire addrCtrlPkg::addrT [addrCtrlPkg::NUM_MASTERS-1:0] masterAaddr,
	input wire addrCtrlPkg::lenT [addrCtrlPkg::NUM_MASTERS-1:0] masterAlen,
	output logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAready,

	// slave address channels
	output addrCtrlPkg::srcIdT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAid,
	output addrCtrlPkg::addrT [addrCtrlPkg::NUM_SLAVES-2:0] slaveAaddr,	// memory slaves only
	output addrCtrlPkg::lenT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAlen,
	output logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAvalid,
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAready,

	// data side report
	output logic dataFifoWr,
	output addrCtrlPkg::srcIdT srcPort,
	output addrCtrlPkg::slaveT destPort
);

	addrCtrlPkg::muxStateT muxState;
	addrCtrlPkg::srcIdT srcReg;			// extended ID of the captured request
	addrCtrlPkg::addrT addrReg;
	addrCtrlPkg::lenT lenReg;
	addrCtrlPkg::slaveT destReg;		// decoded target
	logic takeReq;
	logic slaveHs;						// slave accepts this cycle

	assign takeReq = (muxState == addrCtrlPkg::MUX_IDLE) && grantValid;
	assign slaveHs = (muxState == addrCtrlPkg::MUX_SEND) && slaveAready[destReg];

	assign arbEnable = takeReq;
	assign masterAready = takeReq ? grant : '0;	// one cycle accept of the winner

	// ==============================
	// state machine
	// ==============================
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			muxState <= addrCtrlPkg::MUX_IDLE;
		else if (takeReq)
			muxState <= addrCtrlPkg::MUX_SEND;
		else if (slaveHs)
			muxState <= addrCtrlPkg::MUX_IDLE;	// free again on the edge after handshake
	end

	// capture the granted request
	always_ff @(posedge sysClk)
	begin
		if (takeReq)
		begin
			srcReg <= {grantEnc, masterAid[grantEnc]};	// prefix master number
			addrReg <= masterAaddr[grantEnc];
			lenReg <= masterAlen[grantEnc];
			destReg <= targetSlave[grantEnc];
		end
	end

	// payload to every slave, only the target sees valid
	always_comb
	begin
		for (int s = 0; s < addrCtrlPkg::NUM_SLAVES; s++)
		begin
			slaveAid[s] = srcReg;
			slaveAlen[s] = lenReg;
			slaveAvalid[s] = (muxState == addrCtrlPkg::MUX_SEND) && (int'(destReg) == s);
		end
		for (int s = 0; s < addrCtrlPkg::NUM_SLAVES - 1; s++)
			slaveAaddr[s] = addrReg;
	end

	assign dataFifoWr = slaveHs;		// one pulse per accepted transaction
	assign srcPort = srcReg;
	assign destPort = destReg;

endmodule

`default_nettype wire

// File: hw/addressController.sv
`default_nettype none

module addressController
(
	input wire logic sysClk,
	input wire logic arstN,

	// ==============================
	// master ports
	// ==============================
	input wire addrCtrlPkg::idT [addrCtrlPkg::NUM_MASTERS-1:0] masterAid,
	input wire addrCtrlPkg::addrT [addrCtrlPkg::NUM_MASTERS-1:0] masterAaddr,
	input wire addrCtrlPkg::lenT [addrCtrlPkg::NUM_MASTERS-1:0] masterAlen,
	input wire logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAvalid,
	output logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAready,

	// ==============================
	// slave ports
	// ==============================
	output addrCtrlPkg::srcIdT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAid,
	output addrCtrlPkg::addrT [addrCtrlPkg::NUM_SLAVES-2:0] slaveAaddr,	// no address to derr slave
	output addrCtrlPkg::lenT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAlen,
	output logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAvalid,
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAready,

	// data side
	input wire logic [addrCtrlPkg::NUM_MASTERS-1:0] openTransDec,	// retire one per pulse
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] stopTrans,		// hold new requests per slave
	output logic dataFifoWr,
	output addrCtrlPkg::srcIdT srcPort,
	output addrCtrlPkg::slaveT destPort
);

	addrCtrlPkg::slaveT [addrCtrlPkg::NUM_MASTERS-1:0] targetSlave;	// decoded slave per master
	logic [addrCtrlPkg::NUM_MASTERS-1:0] validQual;
	logic [addrCtrlPkg::NUM_MASTERS-1:0] grant;
	addrCtrlPkg::masterT grantEnc;
	logic grantValid;
	logic arbEnable;

	// one qualify stage per master, acceptance bumps its open count
	for (genvar i = 0; i < addrCtrlPkg::NUM_MASTERS; i++)
	begin : qualBlk
		masterQualify masterQualify_i (
			.sysClk(sysClk),
			.arstN(arstN),
			.masterAddr(masterAaddr[i]),
			.masterValid(masterAvalid[i]),
			.masterId(addrCtrlPkg::masterT'(i)),
			.openTransInc(masterAready[i]),
			.openTransDec(openTransDec[i]),
			.stopTrans(stopTrans),
			.targetSlave(targetSlave[i]),
			.validQual(validQual[i])
		);
	end

	roundRobinArb roundRobinArb_i (
		.sysClk(sysClk),
		.arstN(arstN),
		.requestor(validQual),
		.arbEnable(arbEnable),
		.grant(grant),
		.grantEnc(grantEnc),
		.grantValid(grantValid)
	);

	targetMux targetMux_i (
		.sysClk(sysClk),
		.arstN(arstN),
		.grant(grant),
		.grantEnc(grantEnc),
		.grantValid(grantValid),
		.targetSlave(targetSlave),
		.arbEnable(arbEnable),
		.masterAid(masterAid),
		.masterAaddr(masterAaddr),
		.masterAlen(masterAlen),
		.masterAready(masterAready),
		.slaveAid(slaveAid),
		.slaveAaddr(slaveAaddr),
		.slaveAlen(slaveAlen),
		.slaveAvalid(slaveAvalid),
		.slaveAready(slaveAready),
		.dataFifoWr(dataFifoWr),
		.srcPort(srcPort),
		.destPort(destPort)
	);

endmodule

`default_nettype wire

// File: sim/addressController_assertions.sv
`default_nettype none

module addressController_assertions
(
	input wire logic sysClk,
	input wire logic arstN,
	input wire logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAready,
	input wire addrCtrlPkg::srcIdT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAid,
	input wire addrCtrlPkg::addrT [addrCtrlPkg::NUM_SLAVES-2:0] slaveAaddr,
	input wire addrCtrlPkg::lenT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAlen,
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAvalid,
	input wire logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAready,
	input wire logic dataFifoWr
);
	timeunit 1ns;
	timeprecision 1ps;

	// ==============================
	// slave side
	// ==============================
	validOneHot: assert property (@(posedge sysClk) disable iff (!arstN) $onehot0(slaveAvalid))
		else $error("slaveAvalid drives more than one slave");

	// payload frozen while the slave stalls
	validStable: assert property (@(posedge sysClk) disable iff (!arstN)
		|(slaveAvalid & ~slaveAready) |=> $stable(slaveAvalid) && $stable(slaveAid)
		&& $stable(slaveAaddr) && $stable(slaveAlen))
		else $error("slave request changed before ready");

	reportOnHs: assert property (@(posedge sysClk) disable iff (!arstN)
		dataFifoWr |-> |(slaveAvalid & slaveAready))
		else $error("dataFifoWr without a slave handshake");

	// master side
	readyOneHot: assert property (@(posedge sysClk) disable iff (!arstN) $onehot0(masterAready))
		else $error("masterAready accepts more than one master");

endmodule

bind addressController addressController_assertions addressController_assertions_i (
	.sysClk(sysClk),
	.arstN(arstN),
	.masterAready(masterAready),
	.slaveAid(slaveAid),
	.slaveAaddr(slaveAaddr),
	.slaveAlen(slaveAlen),
	.slaveAvalid(slaveAvalid),
	.slaveAready(slaveAready),
	.dataFifoWr(dataFifoWr)
);

`default_nettype wire

// File: sim/addressControllerTb.sv
`default_nettype none

module addressControllerTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LINES = 32;
	localparam int FAIR_PHASE = 3;		// both masters compete
	localparam int HOLD_PHASE = 4;		// data side suspended
	localparam int STOP_PHASE = 5;		// slave 1 held by stopTrans
	localparam int STOP_SLAVE = 1;
	localparam int LAST_PHASE = 5;

	// ==============================
	// DUT signals
	// ==============================
	logic sysClk = 1'b0;
	logic arstN = 1'b0;
	addrCtrlPkg::idT [addrCtrlPkg::NUM_MASTERS-1:0] masterAid = '0;
	addrCtrlPkg::addrT [addrCtrlPkg::NUM_MASTERS-1:0] masterAaddr = '0;
	addrCtrlPkg::lenT [addrCtrlPkg::NUM_MASTERS-1:0] masterAlen = '0;
	logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAvalid = '0;
	logic [addrCtrlPkg::NUM_MASTERS-1:0] masterAready;
	addrCtrlPkg::srcIdT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAid;
	addrCtrlPkg::addrT [addrCtrlPkg::NUM_SLAVES-2:0] slaveAaddr;
	addrCtrlPkg::lenT [addrCtrlPkg::NUM_SLAVES-1:0] slaveAlen;
	logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAvalid;
	logic [addrCtrlPkg::NUM_SLAVES-1:0] slaveAready = '0;
	logic [addrCtrlPkg::NUM_MASTERS-1:0] openTransDec = '0;
	logic [addrCtrlPkg::NUM_SLAVES-1:0] stopTrans = '0;
	logic dataFifoWr;
	addrCtrlPkg::srcIdT srcPort;
	addrCtrlPkg::slaveT destPort;

	// trace rows, six words each
	logic [31:0] traceMem [0:6*MAX_LINES-1];
	logic traceLoaded = 1'b0;
	int lineCnt = 0;
	int lnPhase [MAX_LINES];
	addrCtrlPkg::masterT lnMaster [MAX_LINES];
	addrCtrlPkg::idT lnId [MAX_LINES];
	addrCtrlPkg::addrT lnAddr [MAX_LINES];
	addrCtrlPkg::lenT lnLen [MAX_LINES];
	addrCtrlPkg::slaveT lnSlave [MAX_LINES];		// expected target

	// master models
	int masterLines [addrCtrlPkg::NUM_MASTERS][MAX_LINES];	// row numbers per master
	int loadCnt [addrCtrlPkg::NUM_MASTERS] = '{default: 0};
	int nextIdx [addrCtrlPkg::NUM_MASTERS] = '{default: 0};
	int curLine [addrCtrlPkg::NUM_MASTERS] = '{default: 0};	// row now on the bus
	logic busy [addrCtrlPkg::NUM_MASTERS] = '{default: 1'b0};
	logic [addrCtrlPkg::NUM_MASTERS-1:0] acceptSnap = '0;

	// slave and data side models
	int seed = 32'h106765de;
	int slaveWait [addrCtrlPkg::NUM_SLAVES] = '{default: 0};
	logic [addrCtrlPkg::NUM_SLAVES-1:0] vldSnap = '0;
	logic [addrCtrlPkg::NUM_SLAVES-1:0] rdySnap = '0;
	logic decHold = 1'b0;
	int decCredit = 0;							// pulses still allowed while held
	int decOwed [addrCtrlPkg::NUM_MASTERS] = '{default: 0};
	int decPaid [addrCtrlPkg::NUM_MASTERS] = '{default: 0};

	// scoreboard
	int acceptQ [$];								// rows in order of acceptance
	int acceptsPerPhase [LAST_PHASE+1] = '{default: 0};
	int reportsPerPhase [LAST_PHASE+1] = '{default: 0};
	int openModel [addrCtrlPkg::NUM_MASTERS] = '{default: 0};
	addrCtrlPkg::slaveT openSlaveModel [addrCtrlPkg::NUM_MASTERS] = '{default: '0};
	int lastMaster = -1;
	int totalReports = 0;

	addressController addressController_i (
		.sysClk(sysClk),
		.arstN(arstN),
		.masterAid(masterAid),
		.masterAaddr(masterAaddr),
		.masterAlen(masterAlen),
		.masterAvalid(masterAvalid),
		.masterAready(masterAready),
		.slaveAid(slaveAid),
		.slaveAaddr(slaveAaddr),
		.slaveAlen(slaveAlen),
		.slaveAvalid(slaveAvalid),
		.slaveAready(slaveAready),
		.openTransDec(openTransDec),
		.stopTrans(stopTrans),
		.dataFifoWr(dataFifoWr),
		.srcPort(srcPort),
		.destPort(destPort)
	);

	initial
	begin
		forever #20 sysClk = ~sysClk;		// 40 ns period
	end

	// ==============================
	// checks
	// ==============================
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkSlave(input string name, input addrCtrlPkg::slaveT got,
		input addrCtrlPkg::slaveT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkSrc(input string name, input addrCtrlPkg::srcIdT got,
		input addrCtrlPkg::srcIdT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkAddr(input string name, input addrCtrlPkg::addrT got,
		input addrCtrlPkg::addrT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkLen(input string name, input addrCtrlPkg::lenT got,
		input addrCtrlPkg::lenT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// hand one phase to the masters and wait until it has drained
	task automatic runPhase(input int p);
		int expected;
		expected = 0;
		if (p == STOP_PHASE)
		begin
			@(posedge sysClk);
			stopTrans[STOP_SLAVE] <= 1'b1;
		end
		@(negedge sysClk);
		decHold = (p == HOLD_PHASE);
		for (int n = 0; n < lineCnt; n++)
		begin
			if (lnPhase[n] == p)
			begin
				masterLines[lnMaster[n]][loadCnt[lnMaster[n]]] = n;
				loadCnt[lnMaster[n]]++;
				expected++;
			end
		end
		if (p == HOLD_PHASE || p == STOP_PHASE)
		begin
			// the last row of these phases must stay blocked
			while (reportsPerPhase[p] < expected - 1)
				@(posedge sysClk);
			repeat (10) @(posedge sysClk);
			if (acceptsPerPhase[p] != expected - 1)
				abortRun($sformatf("phase %0d: a blocked request was accepted", p));
			if (p == HOLD_PHASE)
			begin
				// retire one only, count drops below the limit, other slave still open
				@(negedge sysClk);
				decCredit = 1;
				repeat (10) @(posedge sysClk);
				if (acceptsPerPhase[p] != expected - 1)
					abortRun($sformatf("phase %0d: slave switched with transactions open", p));
			end
			@(posedge sysClk);
			stopTrans <= '0;
			@(negedge sysClk);
			decHold = 1'b0;						// retire the held transactions
		end
		while (reportsPerPhase[p] < expected || openModel[0] != 0 || openModel[1] != 0)
			@(posedge sysClk);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial
	begin
		for (int i = 0; i < 6 * MAX_LINES; i++)
			traceMem[i] = 32'hE000_0000 | i;		// marks words past the end of the file
		$readmemh("sim/addressTrace.txt", traceMem);
		while (lineCnt < MAX_LINES && traceMem[6 * lineCnt] < 32'h100)
		begin
			lnPhase[lineCnt] = int'(traceMem[6 * lineCnt]);
			lnMaster[lineCnt] = addrCtrlPkg::masterT'(traceMem[6 * lineCnt + 1]);
			lnId[lineCnt] = addrCtrlPkg::idT'(traceMem[6 * lineCnt + 2]);
			lnAddr[lineCnt] = addrCtrlPkg::addrT'(traceMem[6 * lineCnt + 3]);
			lnLen[lineCnt] = addrCtrlPkg::lenT'(traceMem[6 * lineCnt + 4]);
			lnSlave[lineCnt] = addrCtrlPkg::slaveT'(traceMem[6 * lineCnt + 5]);
			lineCnt++;
		end
		traceLoaded = 1'b1;
		repeat (2) @(posedge sysClk);
		arstN <= 1'b1;
		for (int p = 1; p <= LAST_PHASE; p++)
			runPhase(p);
		@(posedge sysClk);
		if (acceptQ.size() != 0 || totalReports != lineCnt)
			abortRun($sformatf("%0d of %0d requests reported", totalReports, lineCnt));
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

	initial
	begin
		wait (traceLoaded);
		repeat (lineCnt * 40) @(posedge sysClk);
		abortRun("timeout: the trace did not complete in time");
	end

	// ==============================
	// bus models
	// ==============================
	// masters hold each request until accepted
	always @(posedge sysClk)
	begin
		for (int m = 0; m < addrCtrlPkg::NUM_MASTERS; m++)
		begin
			if (!busy[m] || acceptSnap[m])
			begin
				if (nextIdx[m] < loadCnt[m])
				begin
					curLine[m] = masterLines[m][nextIdx[m]];
					nextIdx[m]++;
					busy[m] = 1'b1;
					masterAvalid[m] <= 1'b1;
					masterAid[m] <= lnId[curLine[m]];
					masterAaddr[m] <= lnAddr[curLine[m]];
					masterAlen[m] <= lnLen[curLine[m]];
				end
				else
				begin
					busy[m] = 1'b0;
					masterAvalid[m] <= 1'b0;
				end
			end
		end
	end

	// slaves answer after 0 to 3 cycles
	always @(posedge sysClk)
	begin
		int d;
		for (int s = 0; s < addrCtrlPkg::NUM_SLAVES; s++)
		begin
			if (vldSnap[s] && rdySnap[s])
			begin
				d = int'($unsigned($random(seed)) % 4);
				slaveWait[s] = d;
				slaveAready[s] <= (d == 0);
			end
			else if (vldSnap[s] && !rdySnap[s])
			begin
				if (slaveWait[s] == 0)
					slaveAready[s] <= 1'b1;
				else
					slaveWait[s]--;
			end
		end
	end

	// data side retires one transaction per pulse
	always @(posedge sysClk)
	begin
		for (int m = 0; m < addrCtrlPkg::NUM_MASTERS; m++)
		begin
			if (decPaid[m] < decOwed[m] && (!decHold || decCredit > 0))
			begin
				openTransDec[m] <= 1'b1;
				decPaid[m]++;
				if (decHold)
					decCredit--;				// one of the allowed pulses used
			end
			else
				openTransDec[m] <= 1'b0;
		end
	end

	// ==============================
	// monitor, mid cycle
	// ==============================
	always @(negedge sysClk)
	begin
		int n;
		addrCtrlPkg::slaveT d;
		addrCtrlPkg::srcIdT expSrc;
		vldSnap = slaveAvalid;
		rdySnap = slaveAready;
		acceptSnap = masterAready;
		if (arstN)
		begin
			for (int m = 0; m < addrCtrlPkg::NUM_MASTERS; m++)
			begin
				if (masterAready[m])
				begin
					n = curLine[m];
					if (!masterAvalid[m])
						abortRun($sformatf("master %0d accepted with no request", m));
					if (openModel[m] >= addrCtrlPkg::OPEN_TRANS_MAX)
						abortRun($sformatf("master %0d over its open limit", m));
					if (openModel[m] != 0 && lnSlave[n] != openSlaveModel[m])
						abortRun($sformatf("master %0d switched slaves while open", m));
					if (stopTrans[lnSlave[n]])
						abortRun($sformatf("request to stopped slave %0d accepted", lnSlave[n]));
					acceptQ.push_back(n);
					acceptsPerPhase[lnPhase[n]]++;
					openSlaveModel[m] = lnSlave[n];
				end
			end
			if (dataFifoWr)
			begin
				if (acceptQ.size() == 0)
					abortRun("dataFifoWr with no accepted request");
				n = acceptQ.pop_front();
				d = lnSlave[n];
				expSrc = {lnMaster[n], lnId[n]};		// master number on top of the ID
				checkSrc("srcPort", srcPort, expSrc);
				checkSlave("destPort", destPort, d);
				if (!(slaveAvalid[d] && slaveAready[d]))
					abortRun("dataFifoWr without a slave handshake");
				checkSrc("slaveAid", slaveAid[d], expSrc);
				checkLen("slaveAlen", slaveAlen[d], lnLen[n]);
				if (int'(d) != addrCtrlPkg::DERR_SLAVE)
					checkAddr("slaveAaddr", slaveAaddr[d], lnAddr[n]);
				if (stopTrans[d])
					abortRun($sformatf("transaction reported to stopped slave %0d", d));
				if (lnPhase[n] == FAIR_PHASE && reportsPerPhase[FAIR_PHASE] > 0
					&& int'(lnMaster[n]) == lastMaster)
					abortRun($sformatf("master %0d served twice in a row", lastMaster));
				lastMaster = int'(lnMaster[n]);
				reportsPerPhase[lnPhase[n]]++;
				totalReports++;
				decOwed[lnMaster[n]]++;				// data side retires it later
			end
			for (int m = 0; m < addrCtrlPkg::NUM_MASTERS; m++)
				openModel[m] = openModel[m] + int'(masterAready[m]) - int'(openTransDec[m]);
		end
	end

endmodule

`default_nettype wire

// File: sim/addressTrace.txt
// columns in hex: phase master id address length expected-slave
// phase 4 holds the data side, phase 5 stops slave 1
1 0 1 01230 07 0
1 0 2 0A450 03 1
1 1 3 0F000 00 1
1 0 0 03FFC 0F 0
2 0 1 05000 01 2
2 1 2 02000 04 2
2 1 0 4A000 02 2
3 0 0 08000 01 1
3 1 1 09000 02 1
3 0 2 0A000 03 1
3 1 3 0B000 04 1
3 0 3 0C000 05 1
3 1 0 0D000 06 1
4 0 1 00100 00 0
4 0 2 01100 01 0
4 0 3 02100 02 0
4 0 0 0E100 03 1
5 0 2 0C800 07 1
5 1 1 60000 08 2
5 1 2 7F000 09 2

// File: compile.f
hw/addrCtrlPkg.sv
hw/masterQualify.sv
hw/roundRobinArb.sv
hw/targetMux.sv
hw/addressController.sv
sim/addressController_assertions.sv
sim/addressControllerTb.sv

// File: run.sh
#!/bin/sh
# build and run the address controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module addressControllerTb -f compile.f -o simv > "$BUILD_LOG" 2>&1
then
	cat "$BUILD_LOG"
	echo "build FAILED"
	exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

if [ "$simStatus" -ne 0 ] || grep -q "tests failed" "$SIM_LOG"; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"
exit 0
